// ==== src/zports_pkg.sv ====
////////////////////////////////////////////////////////////
// shared constants and types of the z80 port block
// port addresses, xxBD subaddresses, bit positions, resets
////////////////////////////////////////////////////////////

package zports_pkg;

	typedef logic [ 7:0] byte_t;
	typedef logic [15:0] addr_t;

	// low address bytes that get decoded
	localparam byte_t port_fe      = 8'hFE; // border, beeper, keyboard
	localparam byte_t port_f6      = 8'hF6; // FE alias
	localparam byte_t port_fc      = 8'hFC; // 7FFD alias
	localparam byte_t port_fd      = 8'hFD; // 7FFD, AY on xxFD with a15
	localparam byte_t port_f7      = 8'hF7; // EFF7
	localparam byte_t port_bf      = 8'hBF; // evo config
	localparam byte_t port_be      = 8'hBE; // nmi end
	localparam byte_t port_bd      = 8'hBD; // readback, break address
	localparam byte_t port_77      = 8'h77; // ATM screen mode and turbo
	localparam byte_t port_ulaplus = 8'h3B;
	localparam byte_t port_kmouse  = 8'hDF;
	localparam byte_t port_kjoy    = 8'h1F;

	// xxBD field select, taken from a[12:8]
	localparam logic [4:0] bd_p7ffd    = 5'h0A;
	localparam logic [4:0] bd_peff7    = 5'h0B;
	localparam logic [4:0] bd_pxx77    = 5'h0C;
	localparam logic [4:0] bd_borderrd = 5'h0F;
	localparam logic [4:0] bd_lobrk    = 5'h10;
	localparam logic [4:0] bd_hibrk    = 5'h11;

	////////////////////////////////////////////////////////////
	// field positions
	localparam int shadow_en_bit = 0; // xxBF
	localparam int romrw_en_bit  = 1;
	localparam int set_nmi_bit   = 3;
	localparam int brk_ena_bit   = 4;
	localparam int pal444_bit    = 5;

	localparam int block48k_bit  = 5; // 7FFD
	localparam int block1m_bit   = 2; // EFF7

	localparam logic [2:0] atm_scr_mode_rst = 3'b011;

	localparam byte_t idle_byte = 8'hFF; // undecoded reads float high

endpackage

// ==== src/zports_ifs.sv ====
////////////////////////////////////////////////////////////
// io_bus_if: fclk strobes, address, data and shadow
// readback_if: register state for the z80 read mux
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface io_bus_if;

	logic                wr_valid; // one fclk cycle per z80 io write
	logic                rd_valid; // one fclk cycle per z80 io read
	zports_pkg::addr_t   addr;
	zports_pkg::byte_t   wdata;
	logic                shadow;   // dos or xxBF shadow enable

	modport src  (output wr_valid, output rd_valid, output addr, output wdata,
		input shadow);
	modport sink (input wr_valid, input rd_valid, input addr, input wdata,
		input shadow);
	// config block is the one that owns shadow
	modport cfg  (input wr_valid, input addr, input wdata, output shadow);

endinterface

interface readback_if;

	zports_pkg::byte_t   p7ffd_raw;  // unmasked 7FFD
	zports_pkg::byte_t   peff7_raw;  // unmasked EFF7
	logic [3:0]          border;
	zports_pkg::byte_t   bf_byte;    // xxBF as read back
	zports_pkg::byte_t   pxx77;      // packed ATM mode
	zports_pkg::addr_t   brk_addr;
	zports_pkg::byte_t   ula_last;   // last ULAplus data byte

	modport pager (output p7ffd_raw, output peff7_raw, output border);
	modport evo   (output bf_byte, output pxx77, output brk_addr);
	modport ula   (output ula_last);
	modport mux   (input p7ffd_raw, input peff7_raw, input border, input bf_byte,
		input pxx77, input brk_addr, input ula_last);

endinterface

// ==== src/io_strobe_sync.sv ====
////////////////////////////////////////////////////////////
// z80 io strobe generator on fclk
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module io_strobe_sync (
	input  logic              fclk,
	input  logic              rst_n,
	input  logic              zpos,   // z80 clock rising phase
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  zports_pkg::addr_t a,
	input  zports_pkg::byte_t din,
	io_bus_if.src             bus
);

	logic [1:0] iowr_smp; // [0] sampled on zpos, [1] previous sample
	logic [1:0] iord_smp;
	logic       wr_pulse;
	logic       rd_pulse;

	always_ff @(posedge fclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_smp <= 2'b00;
			iord_smp <= 2'b00;
			wr_pulse <= 1'b0;
			rd_pulse <= 1'b0;
		end
		else
		begin
			if (zpos)
			begin
				iowr_smp[0] <= ~(iorq_n | wr_n);
				iord_smp[0] <= ~(iorq_n | rd_n);
			end
			iowr_smp[1] <= iowr_smp[0];
			iord_smp[1] <= iord_smp[0];
			// rising edge of the sample, once per z80 cycle
			wr_pulse <= iowr_smp[0] & ~iowr_smp[1];
			rd_pulse <= iord_smp[0] & ~iord_smp[1];
		end
	end

	assign bus.wr_valid = wr_pulse;
	assign bus.rd_valid = rd_pulse;
	assign bus.addr     = a;   // z80 holds address and data for the whole cycle
	assign bus.wdata    = din;

endmodule

// ==== src/port_read_mux.sv ====
////////////////////////////////////////////////////////////
// port hit and external port decode, dataout
// z80 read data mux with xxBD readback
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module port_read_mux (
	input  zports_pkg::addr_t a,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              shadow,
	input  logic              dos,
	input  logic              [4:0] keys_in,   // keyboard columns
	input  logic              tape_read,
	input  zports_pkg::byte_t mus_in,    // kempston mouse
	input  zports_pkg::byte_t kj_in,     // kempston joystick
	readback_if.mux           rb,
	output logic              porthit,
	output logic              external_port,
	output logic              dataout,
	output zports_pkg::byte_t dout
);

	zports_pkg::byte_t loa;
	zports_pkg::byte_t portbd_mux;

	assign loa = a[7:0];

	////////////////////////////////////////////////////////////
	// decode
	always_comb
	begin
		porthit = (loa == zports_pkg::port_fe) || (loa == zports_pkg::port_f6) ||
			(loa == zports_pkg::port_fd) || (loa == zports_pkg::port_fc) ||
			(loa == zports_pkg::port_kmouse) ||
			((loa == zports_pkg::port_kjoy) && !shadow) ||
			((loa == zports_pkg::port_f7) && !shadow) ||   // EFF7 hidden in shadow
			((loa == zports_pkg::port_77) && shadow) ||    // ATM port only in shadow
			(loa == zports_pkg::port_bf) || (loa == zports_pkg::port_be) ||
			(loa == zports_pkg::port_bd) || (loa == zports_pkg::port_ulaplus);
	end

	assign external_port = (loa == zports_pkg::port_fd) && a[15]; // AY at BFFD/FFFD

	assign dataout = porthit & ~iorq_n & ~rd_n & ~external_port;

	////////////////////////////////////////////////////////////
	// xxBD readback field
	always_comb
	begin
		case (a[12:8])
			zports_pkg::bd_p7ffd:    portbd_mux = rb.p7ffd_raw;
			zports_pkg::bd_peff7:    portbd_mux = rb.peff7_raw;
			zports_pkg::bd_pxx77:    portbd_mux = rb.pxx77;
			zports_pkg::bd_borderrd: portbd_mux = {4'b0000, rb.border};
			zports_pkg::bd_lobrk:    portbd_mux = rb.brk_addr[7:0];
			zports_pkg::bd_hibrk:    portbd_mux = rb.brk_addr[15:8];
			default:                 portbd_mux = zports_pkg::idle_byte;
		endcase
	end

	// z80 read data
	always_comb
	begin
		case (loa)
			zports_pkg::port_fe,
			zports_pkg::port_f6:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			zports_pkg::port_kjoy:
				dout = shadow ? zports_pkg::idle_byte : kj_in; // 1F belongs to fdc in shadow
			zports_pkg::port_kmouse:
				dout = mus_in;
			zports_pkg::port_bf:
				dout = rb.bf_byte;
			zports_pkg::port_bd:
				dout = portbd_mux;
			zports_pkg::port_ulaplus:
				dout = rb.ula_last;
			default:
				dout = zports_pkg::idle_byte;
		endcase
	end

endmodule

// ==== src/pager_ports.sv ====
////////////////////////////////////////////////////////////
// 7FFD and EFF7 paging with 1 meg blocking, FE border
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pager_ports (
	input  logic              fclk,
	input  logic              rst_n,
	io_bus_if.sink            bus,
	readback_if.pager         rb,
	output zports_pkg::byte_t p7ffd,
	output zports_pkg::byte_t peff7,
	output logic [3:0]        border,
	output logic              beeper_wr
);

	zports_pkg::byte_t loa;
	zports_pkg::byte_t p7ffd_int; // 2..0 page, 3 screen, 4 rom, 5 block48k, 7..6 high page
	zports_pkg::byte_t peff7_int; // 0 p16c, 2 block1m, 3 ram0, 4 turbo off
	logic              block1m;
	logic              block7ffd;
	logic              portfd_wr;
	logic              portf7_wr;
	logic              portfe_wr;

	assign loa = bus.addr[7:0];

	assign portfd_wr = ((loa == zports_pkg::port_fd) || (loa == zports_pkg::port_fc)) &&
		bus.wr_valid && !bus.addr[15];
	assign portf7_wr = (loa == zports_pkg::port_f7) && bus.addr[8] && !bus.addr[12] &&
		bus.wr_valid && !bus.shadow;  // EEF7 in shadow is not served
	assign portfe_wr = ((loa == zports_pkg::port_fe) || (loa == zports_pkg::port_f6) ||
		(loa == zports_pkg::port_fc)) && bus.wr_valid;

	assign block1m   = peff7_int[zports_pkg::block1m_bit];
	assign block7ffd = p7ffd_int[zports_pkg::block48k_bit] & block1m; // 48k lock

	always_ff @(posedge fclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_int <= 8'h00;
			peff7_int <= 8'h00;
			border    <= 4'h0;
		end
		else
		begin
			if (portfd_wr && !block7ffd)
				p7ffd_int <= bus.wdata;
			if (portf7_wr)
				peff7_int <= bus.wdata;
			if (portfe_wr)
				border <= {~bus.addr[3], bus.wdata[2:0]}; // a3 inverted is bright
		end
	end

	// 128k mode hides the high page bits
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_int[7:5]), p7ffd_int[4:0]};
	assign peff7 = block1m ?
		{peff7_int[7], 1'b0, peff7_int[5:4], 3'b000, peff7_int[0]} : peff7_int;

	assign beeper_wr = (loa == zports_pkg::port_fe) && bus.wr_valid; // FE only, no aliases

	assign rb.p7ffd_raw = p7ffd_int;
	assign rb.peff7_raw = peff7_int;
	assign rb.border    = border;

endmodule

// ==== src/evo_config_ports.sv ====
////////////////////////////////////////////////////////////
// xxBF config, xxBE nmi end, xx77 ATM mode
// xxBD break address write and shadow
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module evo_config_ports (
	input  logic              fclk,
	input  logic              rst_n,
	input  logic              dos,
	io_bus_if.cfg             bus,
	readback_if.evo           rb,
	output logic              romrw_en,
	output logic              set_nmi,
	output logic              brk_ena,
	output logic              pal444_ena,
	output logic              clr_nmi,
	output logic [2:0]        atm_scr_mode,
	output logic              atm_turbo,
	output logic              atm_pen,    // pager off, not inverted
	output logic              atm_cpm_n,  // permanent dos
	output zports_pkg::addr_t brk_addr
);

	zports_pkg::byte_t loa;
	logic [5:0]        bf_bits;  // bit 2 is font write, readback only here
	logic              atm_pen2;
	logic              bf_wr;
	logic              p77_wr;
	logic              bd_wr;

	assign loa = bus.addr[7:0];

	assign bf_wr  = (loa == zports_pkg::port_bf) && bus.wr_valid;
	assign p77_wr = (loa == zports_pkg::port_77) && bus.wr_valid && bus.shadow;
	assign bd_wr  = (loa == zports_pkg::port_bd) && bus.wr_valid;

	assign bus.shadow = dos | bf_bits[zports_pkg::shadow_en_bit];

	////////////////////////////////////////////////////////////
	// xxBF and xx77
	always_ff @(posedge fclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			bf_bits      <= 6'b000000;
			atm_scr_mode <= zports_pkg::atm_scr_mode_rst;
			atm_turbo    <= 1'b0;
			atm_pen      <= 1'b1; // no memory manager
			atm_cpm_n    <= 1'b0; // shadow ports on
			atm_pen2     <= 1'b0;
		end
		else
		begin
			if (bf_wr)
				bf_bits <= bus.wdata[5:0];
			if (p77_wr)
			begin
				atm_scr_mode <= bus.wdata[2:0];
				atm_turbo    <= bus.wdata[3];
				atm_pen      <= ~bus.addr[8];  // mode bits ride on the high address
				atm_cpm_n    <= bus.addr[9];
				atm_pen2     <= ~bus.addr[14];
			end
		end
	end

	// break address, one byte per xxBD subaddress
	always_ff @(posedge fclk)
	begin
		if (bd_wr && (bus.addr[12:8] == zports_pkg::bd_lobrk))
			brk_addr[7:0] <= bus.wdata;
		if (bd_wr && (bus.addr[12:8] == zports_pkg::bd_hibrk))
			brk_addr[15:8] <= bus.wdata;
	end

	assign romrw_en   = bf_bits[zports_pkg::romrw_en_bit];
	assign set_nmi    = bf_bits[zports_pkg::set_nmi_bit];
	assign brk_ena    = bf_bits[zports_pkg::brk_ena_bit];
	assign pal444_ena = bf_bits[zports_pkg::pal444_bit];

	assign clr_nmi = (loa == zports_pkg::port_be) && bus.wr_valid; // nmi handler done

	// readback
	assign rb.bf_byte  = {2'b00, bf_bits};
	assign rb.pxx77    = {~atm_pen2, atm_cpm_n, ~atm_pen, dos, atm_turbo, atm_scr_mode};
	assign rb.brk_addr = brk_addr;

endmodule

// ==== src/ulaplus_ports.sv ====
////////////////////////////////////////////////////////////
// ULAplus select, palette address, enable, palette write
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ulaplus_ports (
	input  logic              fclk,
	input  logic              rst_n,
	io_bus_if.sink            bus,
	readback_if.ula           rb,
	output logic              up_ena,
	output logic [5:0]        up_paladdr,
	output zports_pkg::byte_t up_paldata,
	output logic              up_palwr
);

	logic              up_wr;
	logic              up_select;      // 1 mode group, 0 palette group
	zports_pkg::byte_t up_lastwritten;

	assign up_wr = (bus.addr[7:0] == zports_pkg::port_ulaplus) && bus.wr_valid;

	always_ff @(posedge fclk, negedge rst_n)
	begin
		if (!rst_n)
		begin
			up_select <= 1'b0;
			up_ena    <= 1'b0;
		end
		else if (up_wr && !bus.addr[14]) // BF3B register select
		begin
			if (bus.wdata[7:6] == 2'b01)
				up_select <= 1'b1;
			else if (bus.wdata[7:6] == 2'b00)
				up_select <= 1'b0;
		end
		else if (up_wr && up_select)     // FF3B in mode group
			up_ena <= bus.wdata[0];
	end

	always_ff @(posedge fclk)
	begin
		if (up_wr && !bus.addr[14] && (bus.wdata[7:6] == 2'b00))
			up_paladdr <= bus.wdata[5:0];
		if (up_wr && bus.addr[14])
			up_lastwritten <= bus.wdata;
	end

	assign up_palwr   = up_wr && bus.addr[14] && !up_select;
	assign up_paldata = {bus.wdata[4:2], bus.wdata[7:5], bus.wdata[1:0]}; // G3R3B2 to R3G3B2

	assign rb.ula_last = up_lastwritten;

endmodule

// ==== src/zports_top.sv ====
////////////////////////////////////////////////////////////
// z80 io port block, top level
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module zports_top (
	input  logic              fclk,
	input  logic              rst_n,
	input  logic              zpos,
	input  zports_pkg::addr_t a,
	input  zports_pkg::byte_t din,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	input  logic              dos,
	input  logic [4:0]        keys_in,
	input  logic              tape_read,
	input  zports_pkg::byte_t mus_in,
	input  zports_pkg::byte_t kj_in,
	output logic              porthit,       // internal port, for zxbus iorq gating
	output logic              external_port, // AY
	output logic              dataout,
	output zports_pkg::byte_t dout,
	output zports_pkg::byte_t p7ffd,
	output zports_pkg::byte_t peff7,
	output logic [3:0]        border,
	output logic              beeper_wr,
	output logic              romrw_en,
	output logic              set_nmi,
	output logic              brk_ena,
	output logic              pal444_ena,
	output logic              clr_nmi,
	output logic [2:0]        atm_scr_mode,
	output logic              atm_turbo,
	output logic              atm_pen,
	output logic              atm_cpm_n,
	output zports_pkg::addr_t brk_addr,
	output logic              up_ena,
	output logic [5:0]        up_paladdr,
	output zports_pkg::byte_t up_paldata,
	output logic              up_palwr
);

	io_bus_if   bus ();
	readback_if rb ();

	io_strobe_sync u_strobe (.fclk(fclk), .rst_n(rst_n), .zpos(zpos), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .a(a), .din(din), .bus(bus.src));

	// combinational read side
	port_read_mux u_rdmux (.a(a), .iorq_n(iorq_n), .rd_n(rd_n), .shadow(bus.shadow),
		.dos(dos), .keys_in(keys_in), .tape_read(tape_read), .mus_in(mus_in),
		.kj_in(kj_in), .rb(rb.mux), .porthit(porthit), .external_port(external_port),
		.dataout(dataout), .dout(dout));

	pager_ports u_pager (.fclk(fclk), .rst_n(rst_n), .bus(bus.sink), .rb(rb.pager),
		.p7ffd(p7ffd), .peff7(peff7), .border(border), .beeper_wr(beeper_wr));

	evo_config_ports u_evo (.fclk(fclk), .rst_n(rst_n), .dos(dos), .bus(bus.cfg),
		.rb(rb.evo), .romrw_en(romrw_en), .set_nmi(set_nmi), .brk_ena(brk_ena),
		.pal444_ena(pal444_ena), .clr_nmi(clr_nmi), .atm_scr_mode(atm_scr_mode),
		.atm_turbo(atm_turbo), .atm_pen(atm_pen), .atm_cpm_n(atm_cpm_n),
		.brk_addr(brk_addr));

	ulaplus_ports u_ula (.fclk(fclk), .rst_n(rst_n), .bus(bus.sink), .rb(rb.ula),
		.up_ena(up_ena), .up_paladdr(up_paladdr), .up_paldata(up_paldata),
		.up_palwr(up_palwr));

endmodule

// ==== bench/zports_assertions.sv ====
////////////////////////////////////////////////////////////
// strobe and decode assertions, bound into the top level
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module zports_assertions (
	input logic fclk,
	input logic rst_n,
	input logic wr_valid,
	input logic rd_valid,
	input logic porthit,
	input logic dataout
);

	// one fclk cycle per z80 cycle
	wr_one_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		wr_valid |=> !wr_valid)
		else $error("wr_valid wider than one cycle");
	rd_one_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		rd_valid |=> !rd_valid)
		else $error("rd_valid wider than one cycle");
	rd_wr_apart: assert property (@(posedge fclk) disable iff (!rst_n)
		!(wr_valid && rd_valid))
		else $error("rd_valid and wr_valid together");
	dataout_hit: assert property (@(posedge fclk) disable iff (!rst_n)
		dataout |-> porthit)
		else $error("dataout without porthit");

endmodule

bind zports_top zports_assertions u_asrt (.fclk(fclk), .rst_n(rst_n),
	.wr_valid(bus.wr_valid), .rd_valid(bus.rd_valid), .porthit(porthit),
	.dataout(dataout));

// ==== bench/zports_checker.sv ====
////////////////////////////////////////////////////////////
// watches dut outputs, compares with expected case values
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module zports_checker (
	input  logic              fclk,
	input  logic              op_start,
	input  logic              chk_val,
	input  logic              chk_pulse,
	input  logic              report,
	input  logic [3:0]        exp_field,
	input  logic [15:0]       exp_value,
	input  logic [2:0]        exp_pulses, // {up_palwr, clr_nmi, beeper_wr}
	input  logic              porthit,
	input  logic              external_port,
	input  logic              dataout,
	input  zports_pkg::byte_t dout,
	input  zports_pkg::byte_t p7ffd,
	input  zports_pkg::byte_t peff7,
	input  logic [3:0]        border,
	input  logic              beeper_wr,
	input  logic              romrw_en,
	input  logic              set_nmi,
	input  logic              brk_ena,
	input  logic              pal444_ena,
	input  logic              clr_nmi,
	input  logic [2:0]        atm_scr_mode,
	input  logic              atm_turbo,
	input  logic              atm_pen,
	input  logic              atm_cpm_n,
	input  zports_pkg::addr_t brk_addr,
	input  logic              up_ena,
	input  logic [5:0]        up_paladdr,
	input  zports_pkg::byte_t up_paldata,
	input  logic              up_palwr,
	output int                errors
);

	int          n_checks = 0;
	int          val_errs = 0;
	int          pls_errs = 0;
	int          cnt [3];
	logic [15:0] got;

	assign errors = val_errs + pls_errs;

	// sampled mid-cycle, inputs move just after posedge
	always @(negedge fclk)
	begin
		if (op_start)
		begin
			cnt[0] = 0;
			cnt[1] = 0;
			cnt[2] = 0;
		end
		else
		begin
			cnt[0] = cnt[0] + int'(beeper_wr);
			cnt[1] = cnt[1] + int'(clr_nmi);
			cnt[2] = cnt[2] + int'(up_palwr);
		end
		if (chk_val && exp_field != 4'h0)
		begin
			case (exp_field)
				4'h1: got = {8'h00, p7ffd};
				4'h2: got = {8'h00, peff7};
				4'h3: got = {12'h000, border};
				4'h4: got = {8'h00, dout};
				4'h5: got = {12'h000, pal444_ena, brk_ena, set_nmi, romrw_en};
				4'h6: got = {10'h000, atm_cpm_n, atm_pen, atm_turbo, atm_scr_mode};
				4'h7: got = {10'h000, up_paladdr};
				4'h8: got = {8'h00, up_paldata};
				4'h9: got = {15'h0000, up_ena};
				4'hA: got = {13'h0000, porthit, external_port, dataout};
				4'hB: got = brk_addr;
				default: got = 16'hDEAD; // unknown field code
			endcase
			n_checks = n_checks + 1;
			if (got !== exp_value)
			begin
				val_errs = val_errs + 1;
				$display("[ERROR] %0t field %0h got %h expected %h", $time, exp_field,
					got, exp_value);
			end
		end
		if (chk_pulse)
		begin
			for (int i = 0; i < 3; i++)
			begin
				n_checks = n_checks + 1;
				if (cnt[i] != int'(exp_pulses[i]))
				begin
					pls_errs = pls_errs + 1;
					$display("[ERROR] %0t strobe %0d pulsed %0d times, expected %0d",
						$time, i, cnt[i], exp_pulses[i]);
				end
			end
		end
	end

	always @(posedge report)
		$display("checks %0d, value errors %0d, strobe errors %0d", n_checks, val_errs,
			pls_errs);

endmodule

// ==== bench/zports_tb.sv ====
////////////////////////////////////////////////////////////
// testbench top: clock, reset, zpos, file-driven z80 io cycles
// lfsr idle gaps and the cycle timeout
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module zports_tb;

	localparam int max_cases = 64;
	localparam int words     = 7;  // op, addr, data, dos, field, expected, pulses
	localparam int hold_cyc  = 12; // one z80 io cycle
	localparam int rel_cyc   = 4;  // bus released for at least one zpos

	logic              fclk = 1'b0;
	logic              rst_n;
	logic              zpos;
	zports_pkg::addr_t a;
	zports_pkg::byte_t din;
	logic              iorq_n;
	logic              rd_n;
	logic              wr_n;
	logic              dos;
	logic [4:0]        keys_in;
	logic              tape_read;
	zports_pkg::byte_t mus_in;
	zports_pkg::byte_t kj_in;
	logic              porthit;
	logic              external_port;
	logic              dataout;
	zports_pkg::byte_t dout;
	zports_pkg::byte_t p7ffd;
	zports_pkg::byte_t peff7;
	logic [3:0]        border;
	logic              beeper_wr;
	logic              romrw_en;
	logic              set_nmi;
	logic              brk_ena;
	logic              pal444_ena;
	logic              clr_nmi;
	logic [2:0]        atm_scr_mode;
	logic              atm_turbo;
	logic              atm_pen;
	logic              atm_cpm_n;
	zports_pkg::addr_t brk_addr;
	logic              up_ena;
	logic [5:0]        up_paladdr;
	zports_pkg::byte_t up_paldata;
	logic              up_palwr;

	// checker control
	logic              op_start;
	logic              chk_val;
	logic              chk_pulse;
	logic              report;
	logic [3:0]        exp_field;
	logic [15:0]       exp_value;
	logic [2:0]        exp_pulses;
	int                errors;

	logic [31:0]       cases_mem [0:max_cases*words-1];
	logic [31:0]       lfsr;
	logic [1:0]        zcnt = 2'd0;
	int                n_cases;
	int                cycle_cnt = 0;
	int                limit = 0;

	zports_top dut (.*);

	zports_checker chk (.*);

	always #50 fclk = ~fclk; // 100 ns period

	// zpos one cycle in four
	always @(posedge fclk)
	begin
		#1;
		zcnt = zcnt + 2'd1;
		zpos = (zcnt == 2'd0);
	end

	always @(posedge fclk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (limit > 0 && cycle_cnt > limit)
		begin
			$display("timeout: run went past %0d cycles", limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic run_case(input int idx);
		logic [31:0] op;
		int          gap;
		begin
			op = cases_mem[idx*words];
			@(posedge fclk);
			#1;
			a          = cases_mem[idx*words+1][15:0];
			din        = cases_mem[idx*words+2][7:0];
			dos        = cases_mem[idx*words+3][0];
			exp_field  = cases_mem[idx*words+4][3:0];
			exp_value  = cases_mem[idx*words+5][15:0];
			exp_pulses = cases_mem[idx*words+6][2:0];
			op_start   = 1'b1;
			if (op == 32'd1)
			begin
				iorq_n = 1'b0;
				wr_n   = 1'b0;
			end
			else if (op == 32'd2)
			begin
				iorq_n = 1'b0;
				rd_n   = 1'b0;
			end
			for (int h = 1; h < hold_cyc; h++)
			begin
				@(posedge fclk);
				#1;
				op_start = 1'b0;
				chk_val  = (h == hold_cyc - 1); // last cycle of the hold
			end
			@(posedge fclk);
			#1;
			chk_val = 1'b0;
			iorq_n  = 1'b1;
			rd_n    = 1'b1;
			wr_n    = 1'b1;
			// idle gap 1..8
			gap = 1;
			for (int b = 0; b < 3; b++)
			begin
				lfsr = lfsr_next(lfsr);
				gap  = gap + (int'(lfsr[0]) << b);
			end
			repeat (rel_cyc + gap - 1) @(posedge fclk);
			#1;
			chk_pulse = 1'b1;
			@(posedge fclk);
			#1;
			chk_pulse = 1'b0;
		end
	endtask

	initial
	begin
		rst_n      = 1'b0;
		zpos       = 1'b0;
		a          = 16'h0000;
		din        = 8'h00;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		dos        = 1'b0;
		keys_in    = 5'h13;
		tape_read  = 1'b1;
		mus_in     = 8'hC4;
		kj_in      = 8'h5A;
		op_start   = 1'b0;
		chk_val    = 1'b0;
		chk_pulse  = 1'b0;
		report     = 1'b0;
		exp_field  = 4'h0;
		exp_value  = 16'h0000;
		exp_pulses = 3'b000;
		lfsr       = 32'h760959f6;
		for (int i = 0; i < max_cases*words; i++)
			cases_mem[i] = 32'hFFFFFFFF; // end marker
		$readmemh("bench/zports_cases.txt", cases_mem);
		n_cases = 0;
		while (n_cases < max_cases && cases_mem[n_cases*words] != 32'hFFFFFFFF)
			n_cases = n_cases + 1;
		limit = n_cases * 24 + 100;
		repeat (4) @(posedge fclk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < n_cases; i++)
			run_case(i);
		@(posedge fclk);
		report = 1'b1;
		#1;
		if (errors == 0 && n_cases > 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== bench/zports_cases.txt ====
// op(0 idle 1 write 2 read) addr data dos field expected pulses{palwr,clr_nmi,beeper}
// field 1 p7ffd 2 peff7 3 border 4 dout 5 cfg 6 atm 7 paladdr 8 paldata 9 up_ena A hit B brk
1 7FFD D7 0 1 00D7 0
1 00FE 05 0 3 0005 1
1 00F6 03 0 3 000B 0
2 0FBD 00 0 4 000B 0
1 EFF7 04 0 1 0017 0
0 0000 00 0 2 0000 0
1 7FFD 30 0 1 0010 0
1 7FFD 07 0 1 0010 0
2 0ABD 00 0 4 0030 0
1 EFF7 00 0 1 0030 0
1 00BF 1A 0 5 0007 0
2 00BF 00 0 4 001A 0
1 0077 0C 0 6 0013 0
1 0377 0C 1 6 002C 0
1 00BF 01 0 5 0000 0
1 0177 05 0 6 0005 0
2 001F 00 0 4 00FF 0
1 00BF 00 0 0 0000 0
2 001F 00 0 4 005A 0
2 00FE 00 0 4 00D3 0
2 0012 00 0 4 00FF 0
2 00FE 00 0 A 0005 0
2 FFFD 00 0 A 0006 0
1 00BE 00 0 0 0000 2
1 10BD 34 0 0 0000 0
1 11BD 12 0 B 1234 0
1 BF3B 05 0 7 0005 0
1 FF3B 1C 0 8 00E0 4
1 BF3B 40 0 0 0000 0
1 FF3B 01 0 9 0001 0
2 003B 00 0 4 0001 0

// ==== filelist.f ====
src/zports_pkg.sv
src/zports_ifs.sv
src/io_strobe_sync.sv
src/port_read_mux.sv
src/pager_ports.sv
src/evo_config_ports.sv
src/ulaplus_ports.sv
src/zports_top.sv
bench/zports_assertions.sv
bench/zports_checker.sv
bench/zports_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the port block testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module zports_tb \
	-o zports_sim > sim.log 2>&1 \
	&& ./obj_dir/zports_sim >> sim.log 2>&1 \
	|| echo "TESTS FAILED" >> sim.log
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
